// File: project.f
source/riscv_pkg.sv
source/riscv_v_pkg.sv
source/riscv_v_decode.sv
source/riscv_v_lane_alu.sv
source/riscv_v_compare.sv
source/riscv_v_writeback.sv
source/riscv_v.sv
testbench/riscv_v_tb.sv

// File: source/riscv_pkg.sv
////////////////////////////////////////
// RISC-V scalar core types
// Integer register and instruction word
// as seen by the integer pipeline
////////////////////////////////////////

package riscv_pkg;

    // Integer datapath width
    localparam int RISCV_XLEN = 32;

    // One integer register value
    typedef logic [RISCV_XLEN-1:0] riscv_data_t;

    // Raw instruction word from fetch
    typedef logic [31:0] riscv_instruction_t;

endpackage: riscv_pkg

// File: source/riscv_v.sv
////////////////////////////////////////
// RISC-V vector execution unit top
// Decode, element ALU, compare unit and
// writeback combiner
////////////////////////////////////////

module riscv_v (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          clear_pipe,
    input  logic                          riscv_stall,
    // Instruction from the integer pipeline
    input  riscv_pkg::riscv_instruction_t instruction_id,
    input  logic                          instruction_valid_id,
    // Integer register file
    input  riscv_pkg::riscv_data_t        int_rf_rd_data_id,
    output riscv_pkg::riscv_data_t        int_rf_wr_data_wb,
    output logic                          int_rf_wr_en_wb,
    // CSR write
    input  riscv_pkg::riscv_data_t        ext_data_in,
    input  logic                          ext_wr_vl,
    // Debug read
    input  riscv_v_pkg::riscv_v_rf_addr_t syn_addr,
    output riscv_v_pkg::riscv_v_data_t    syn_data
);

    import riscv_v_pkg::*;

    riscv_v_exe_t     exe;
    riscv_v_data_t    alu_result;
    riscv_v_data_t    cmp_result;
    riscv_v_mask_t    cmp_flags;
    logic             rf_wr_en;
    riscv_v_rf_addr_t rf_wr_addr;
    riscv_v_data_t    rf_wr_data;

    riscv_v_decode v_decode (
        .clk(clk),
        .reset(reset),
        .clear_pipe(clear_pipe),
        .riscv_stall(riscv_stall),
        .instruction_valid_id(instruction_valid_id),
        .instruction_id(instruction_id),
        .int_rf_rd_data_id(int_rf_rd_data_id),
        .ext_data_in(ext_data_in),
        .ext_wr_vl(ext_wr_vl),
        .rf_wr_en(rf_wr_en),
        .rf_wr_addr(rf_wr_addr),
        .rf_wr_data(rf_wr_data),
        .syn_addr(syn_addr),
        .exe(exe),
        .syn_data(syn_data)
    );

    // Execute units side by side
    riscv_v_lane_alu v_lane_alu (
        .exe(exe),
        .result(alu_result)
    );

    riscv_v_compare v_compare (
        .exe(exe),
        .result(cmp_result),
        .flags(cmp_flags)
    );

    riscv_v_writeback v_writeback (
        .clk(clk),
        .reset(reset),
        .riscv_stall(riscv_stall),
        .exe(exe),
        .alu_result(alu_result),
        .cmp_result(cmp_result),
        .cmp_flags(cmp_flags),
        .rf_wr_en(rf_wr_en),
        .rf_wr_addr(rf_wr_addr),
        .rf_wr_data(rf_wr_data),
        .int_rf_wr_data_wb(int_rf_wr_data_wb),
        .int_rf_wr_en_wb(int_rf_wr_en_wb)
    );

endmodule: riscv_v

// File: source/riscv_v_compare.sv
////////////////////////////////////////
// RISC-V vector compare unit
// Signed compare, min/max and mask bits
////////////////////////////////////////

module riscv_v_compare (
    input  riscv_v_pkg::riscv_v_exe_t  exe,
    output riscv_v_pkg::riscv_v_data_t result,
    output riscv_v_pkg::riscv_v_mask_t flags
);

    import riscv_v_pkg::*;

    riscv_v_mask_t lane_eq;
    riscv_v_mask_t lane_lt;

    always_comb begin
        for (int i = 0; i < RISCV_V_LANES; i++) begin
            lane_eq[i] = exe.srcb[i] == exe.srca[i];
            lane_lt[i] = $signed(exe.srcb[i]) < $signed(exe.srca[i]);

            // Same less-than picks min or max
            case (exe.opcode)
                VMIN: begin
                    result[i] = lane_lt[i] ? exe.srcb[i] : exe.srca[i];
                end
                VMAX: begin
                    result[i] = lane_lt[i] ? exe.srca[i] : exe.srcb[i];
                end
                default: begin
                    result[i] = '0;
                end
            endcase

            flags[i] = (exe.opcode == VMSEQ) ? lane_eq[i] : lane_lt[i];
        end
    end

endmodule: riscv_v_compare

// File: source/riscv_v_decode.sv
////////////////////////////////////////
// RISC-V vector decode stage
// Register file, vl, write bypass and
// the decode/execute pipeline register
////////////////////////////////////////

module riscv_v_decode (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         clear_pipe,
    input  logic                         riscv_stall,
    input  logic                         instruction_valid_id,
    input  riscv_pkg::riscv_instruction_t instruction_id,
    input  riscv_pkg::riscv_data_t       int_rf_rd_data_id,
    input  riscv_pkg::riscv_data_t       ext_data_in,
    input  logic                         ext_wr_vl,
    input  logic                         rf_wr_en,
    input  riscv_v_pkg::riscv_v_rf_addr_t rf_wr_addr,
    input  riscv_v_pkg::riscv_v_data_t   rf_wr_data,
    input  riscv_v_pkg::riscv_v_rf_addr_t syn_addr,
    output riscv_v_pkg::riscv_v_exe_t    exe,
    output riscv_v_pkg::riscv_v_data_t   syn_data
);

    import riscv_v_pkg::*;

    riscv_v_instr_t  instr;
    riscv_v_data_t   vrf [RISCV_V_NUM_REGS];
    riscv_v_vl_t     vl;
    riscv_v_data_t   vs1_data;
    riscv_v_data_t   vs2_data;
    riscv_v_data_t   vd_data;
    riscv_v_data_t   v0_data;
    riscv_v_data_t   scalar_bcast;
    riscv_v_data_t   imm_bcast;
    riscv_v_data_t   srca;
    riscv_v_elem_t   imm_elem;
    logic            accept;

    assign instr  = riscv_v_instr_t'(instruction_id);
    assign accept = instruction_valid_id && !riscv_stall;

    // Vector register file
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RISCV_V_NUM_REGS; i++) begin
                vrf[i] <= '0;
            end
        end else if (rf_wr_en) begin
            vrf[rf_wr_addr] <= rf_wr_data;
        end
    end

    // vl clamps to the lane count
    always_ff @(posedge clk) begin
        if (reset) begin
            vl <= RISCV_V_VL_MAX;
        end else if (ext_wr_vl) begin
            if (ext_data_in > RISCV_V_LANES) begin
                vl <= RISCV_V_VL_MAX;
            end else begin
                vl <= ext_data_in[$bits(riscv_v_vl_t)-1:0];
            end
        end
    end

    // Forward the write in flight from writeback
    assign vs1_data = (rf_wr_en && rf_wr_addr == instr.vs1) ? rf_wr_data : vrf[instr.vs1];
    assign vs2_data = (rf_wr_en && rf_wr_addr == instr.vs2) ? rf_wr_data : vrf[instr.vs2];
    assign vd_data  = (rf_wr_en && rf_wr_addr == instr.vd)  ? rf_wr_data : vrf[instr.vd];
    assign v0_data  = (rf_wr_en && rf_wr_addr == '0)        ? rf_wr_data : vrf[0];

    assign syn_data = vrf[syn_addr];

    // Scalar and immediate copied to every lane
    assign imm_elem     = {{(RISCV_V_ELEN-5){instr.vs1[4]}}, instr.vs1};
    assign scalar_bcast = {RISCV_V_LANES{int_rf_rd_data_id[RISCV_V_ELEN-1:0]}};
    assign imm_bcast    = {RISCV_V_LANES{imm_elem}};

    always_comb begin
        if (instr.opcode == VMV_V_X || instr.form == FORM_VX) begin
            srca = scalar_bcast;
        end else if (instr.form == FORM_VI) begin
            srca = imm_bcast;
        end else begin
            srca = vs1_data;
        end
    end

    // Stall holds exe, clear drops the valid bit
    always_ff @(posedge clk) begin
        if (reset) begin
            exe <= '0;
        end else begin
            if (!riscv_stall) begin
                exe.valid  <= accept;
                exe.opcode <= instr.opcode;
                exe.vd     <= instr.vd;
                exe.vm     <= instr.vm;
                exe.srca   <= srca;
                exe.srcb   <= vs2_data;
                exe.old_vd <= vd_data;
                exe.mask   <= v0_data[0][RISCV_V_LANES-1:0];
                exe.vl     <= vl;
            end
            if (clear_pipe) begin
                exe.valid <= 1'b0;
            end
        end
    end

endmodule: riscv_v_decode

// File: source/riscv_v_lane_alu.sv
////////////////////////////////////////
// RISC-V vector element ALU
// Add, subtract, logic and shift left,
// each lane on its own
////////////////////////////////////////

module riscv_v_lane_alu (
    input  riscv_v_pkg::riscv_v_exe_t  exe,
    output riscv_v_pkg::riscv_v_data_t result
);

    import riscv_v_pkg::*;

    // Operation is vs2 op vs1, srcb op srca
    always_comb begin
        for (int i = 0; i < RISCV_V_LANES; i++) begin
            case (exe.opcode)
                VADD: begin
                    result[i] = exe.srcb[i] + exe.srca[i];
                end
                VSUB: begin
                    result[i] = exe.srcb[i] - exe.srca[i];
                end
                VAND: begin
                    result[i] = exe.srcb[i] & exe.srca[i];
                end
                VOR: begin
                    result[i] = exe.srcb[i] | exe.srca[i];
                end
                VXOR: begin
                    result[i] = exe.srcb[i] ^ exe.srca[i];
                end
                VSLL: begin
                    result[i] = exe.srcb[i] << exe.srca[i][RISCV_V_SHAMT_W-1:0];
                end
                // Broadcast scalar already sits in srca
                VMV_V_X: begin
                    result[i] = exe.srca[i];
                end
                default: begin
                    result[i] = '0;
                end
            endcase
        end
    end

endmodule: riscv_v_lane_alu

// File: source/riscv_v_pkg.sv
////////////////////////////////////////
// RISC-V vector unit definitions
// Lane geometry, opcodes, operand forms
// and the decode to execute bundle
////////////////////////////////////////

package riscv_v_pkg;

    localparam int RISCV_V_LANES    = 4;
    localparam int RISCV_V_ELEN     = 8;
    localparam int RISCV_V_NUM_REGS = 32;
    // Shift amount uses log2 of the element width
    localparam int RISCV_V_SHAMT_W  = $clog2(RISCV_V_ELEN);

    typedef logic [RISCV_V_ELEN-1:0] riscv_v_elem_t;
    // Element 0 sits in the low byte
    typedef riscv_v_elem_t [RISCV_V_LANES-1:0] riscv_v_data_t;
    typedef logic [4:0] riscv_v_rf_addr_t;
    typedef logic [RISCV_V_LANES-1:0] riscv_v_mask_t;
    typedef logic [2:0] riscv_v_vl_t;

    localparam riscv_v_vl_t RISCV_V_VL_MAX = riscv_v_vl_t'(RISCV_V_LANES);

    typedef enum logic [3:0] {
        VADD, VSUB, VAND, VOR, VXOR, VSLL,
        VMIN, VMAX, VMSEQ, VMSLT, VMV_V_X, VMV_X_S
    } riscv_v_opcode_e;

    typedef enum logic [1:0] {
        FORM_VV, FORM_VX, FORM_VI
    } riscv_v_form_e;

    // Instruction word layout, vs1 carries the immediate in FORM_VI
    typedef struct packed {
        logic [9:0]       zero;
        riscv_v_opcode_e  opcode;
        riscv_v_form_e    form;
        logic             vm;
        riscv_v_rf_addr_t vs2;
        riscv_v_rf_addr_t vs1;
        riscv_v_rf_addr_t vd;
    } riscv_v_instr_t;

    // Pipeline register between decode and execute
    typedef struct packed {
        logic             valid;
        riscv_v_opcode_e  opcode;
        riscv_v_rf_addr_t vd;
        logic             vm;
        riscv_v_data_t    srca;
        riscv_v_data_t    srcb;
        riscv_v_data_t    old_vd;
        riscv_v_mask_t    mask;
        riscv_v_vl_t      vl;
    } riscv_v_exe_t;

endpackage: riscv_v_pkg

// File: source/riscv_v_writeback.sv
////////////////////////////////////////
// RISC-V vector writeback
// Merges unit results under mask and vl,
// drives the register and integer ports
////////////////////////////////////////

module riscv_v_writeback (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          riscv_stall,
    input  riscv_v_pkg::riscv_v_exe_t     exe,
    input  riscv_v_pkg::riscv_v_data_t    alu_result,
    input  riscv_v_pkg::riscv_v_data_t    cmp_result,
    input  riscv_v_pkg::riscv_v_mask_t    cmp_flags,
    output logic                          rf_wr_en,
    output riscv_v_pkg::riscv_v_rf_addr_t rf_wr_addr,
    output riscv_v_pkg::riscv_v_data_t    rf_wr_data,
    output riscv_pkg::riscv_data_t        int_rf_wr_data_wb,
    output logic                          int_rf_wr_en_wb
);

    import riscv_pkg::*;
    import riscv_v_pkg::*;

    riscv_v_mask_t active;
    riscv_v_data_t new_data;
    riscv_v_data_t merged;
    logic          is_mask_op;
    logic          is_minmax;
    logic          is_move_x;

    assign is_mask_op = exe.opcode inside {VMSEQ, VMSLT};
    assign is_minmax  = exe.opcode inside {VMIN, VMAX};
    assign is_move_x  = exe.opcode == VMV_X_S;
    assign new_data   = is_minmax ? cmp_result : alu_result;

    // Lane enabled below vl and by v0 when masked
    always_comb begin
        for (int i = 0; i < RISCV_V_LANES; i++) begin
            active[i] = (i < exe.vl) && (exe.vm || exe.mask[i]);
        end
    end

    always_comb begin
        merged = exe.old_vd;
        if (is_mask_op) begin
            // Mask result lives in the low bits only
            merged = '0;
            for (int i = 0; i < RISCV_V_LANES; i++) begin
                merged[0][i] = active[i] ? cmp_flags[i] : exe.old_vd[0][i];
            end
        end else begin
            for (int i = 0; i < RISCV_V_LANES; i++) begin
                if (active[i]) begin
                    merged[i] = new_data[i];
                end
            end
        end
    end

    assign rf_wr_en   = exe.valid && !riscv_stall && !is_move_x;
    assign rf_wr_addr = exe.vd;
    assign rf_wr_data = merged;

    always_ff @(posedge clk) begin
        if (reset) begin
            int_rf_wr_en_wb <= 1'b0;
        end else begin
            int_rf_wr_en_wb <= exe.valid && !riscv_stall && is_move_x;
        end
    end

    // Element 0 of vs2, sign extended
    always_ff @(posedge clk) begin
        if (exe.valid && is_move_x) begin
            int_rf_wr_data_wb <= {{(RISCV_XLEN-RISCV_V_ELEN){exe.srcb[0][RISCV_V_ELEN-1]}},
                                  exe.srcb[0]};
        end
    end

endmodule: riscv_v_writeback

// File: testbench/riscv_v_tb.sv
////////////////////////////////////////
// Testbench for the RISC-V vector unit
// Applies a table of instructions and
// checks register and integer results
////////////////////////////////////////

module riscv_v_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import riscv_v_pkg::*;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] scalar;
        logic        vl_wr;
        logic [31:0] vl_val;
        logic [1:0]  stall;
        logic        clear;
        logic        chain;
        logic [4:0]  rd;
        logic [31:0] old_vec;
        logic [31:0] exp_vec;
        logic        exp_int_en;
        logic [31:0] exp_int;
    } test_row_t;

    logic                          clk;
    logic                          reset;
    logic                          clear_pipe;
    logic                          riscv_stall;
    riscv_pkg::riscv_instruction_t instruction_id;
    logic                          instruction_valid_id;
    riscv_pkg::riscv_data_t        int_rf_rd_data_id;
    riscv_pkg::riscv_data_t        int_rf_wr_data_wb;
    logic                          int_rf_wr_en_wb;
    riscv_pkg::riscv_data_t        ext_data_in;
    logic                          ext_wr_vl;
    riscv_v_rf_addr_t              syn_addr;
    riscv_v_data_t                 syn_data;

    test_row_t   rows[$];
    logic [31:0] model_vrf [32];
    int          model_vl;
    int          errors;
    int          int_pulses;
    logic [31:0] int_seen;
    bit          table_ready;

    riscv_v i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] encode(riscv_v_opcode_e op, riscv_v_form_e form, logic vm,
                                           logic [4:0] vs2, logic [4:0] vs1, logic [4:0] vd);
        return {10'b0, op, form, vm, vs2, vs1, vd};
    endfunction

    // Element rule, b from vs2 and a from the second operand
    function automatic logic [7:0] lane_op(riscv_v_opcode_e op, logic [7:0] b, logic [7:0] a);
        case (op)
            VADD:    return b + a;
            VSUB:    return b - a;
            VAND:    return b & a;
            VOR:     return b | a;
            VXOR:    return b ^ a;
            VSLL:    return b << a[2:0];
            VMIN:    return ($signed(b) < $signed(a)) ? b : a;
            VMAX:    return ($signed(b) < $signed(a)) ? a : b;
            VMSEQ:   return {7'b0, b == a};
            VMSLT:   return {7'b0, $signed(b) < $signed(a)};
            VMV_V_X: return a;
            default: return 8'h00;
        endcase
    endfunction

    // Appends a row and updates the register model; vl_val < 0 leaves vl alone
    task automatic add_row(input logic [31:0] instr, input logic [31:0] scalar,
                           input logic [4:0] rd, input int vl_val, input int stall,
                           input bit clear, input bit chain);
        test_row_t       row;
        riscv_v_opcode_e op;
        logic [7:0]      a;
        logic [7:0]      b;
        logic [7:0]      r;
        logic [31:0]     result;
        bit              active;
        bit              is_mask;
        op = riscv_v_opcode_e'(instr[21:18]);
        is_mask = (op == VMSEQ) || (op == VMSLT);
        row = '0;
        row.instr = instr;
        row.scalar = scalar;
        row.rd = rd;
        row.stall = stall;
        row.clear = clear;
        row.chain = chain;
        row.old_vec = model_vrf[rd];
        if (vl_val >= 0) begin
            row.vl_wr = 1'b1;
            row.vl_val = vl_val;
            model_vl = (vl_val > 4) ? 4 : vl_val;
        end
        result = model_vrf[instr[4:0]];
        if (is_mask) begin
            result[31:4] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            b = model_vrf[instr[14:10]][8*i +: 8];
            if (op == VMV_V_X || instr[17:16] == FORM_VX) begin
                a = scalar[7:0];
            end else if (instr[17:16] == FORM_VI) begin
                a = {{3{instr[9]}}, instr[9:5]};
            end else begin
                a = model_vrf[instr[9:5]][8*i +: 8];
            end
            active = (i < model_vl) && (instr[15] || model_vrf[0][i]);
            r = lane_op(op, b, a);
            if (active && is_mask) begin
                result[i] = r[0];
            end else if (active) begin
                result[8*i +: 8] = r;
            end
        end
        if (op == VMV_X_S) begin
            row.exp_int_en = 1'b1;
            row.exp_int = {{24{model_vrf[instr[14:10]][7]}}, model_vrf[instr[14:10]][7:0]};
        end else if (!clear) begin
            model_vrf[instr[4:0]] = result;
        end
        row.exp_vec = model_vrf[rd];
        rows.push_back(row);
    endtask

    // Narrowing vl step by step gives each lane its own value
    task automatic load_vector(input logic [4:0] vd, input logic [31:0] elems);
        for (int n = 4; n >= 1; n--) begin
            add_row(encode(VMV_V_X, FORM_VX, 1'b1, 5'd0, 5'd0, vd), elems[8*(n-1) +: 8], vd,
                    (n == 4) ? 9 : n, 0, 0, 0);
        end
    endtask

    task automatic build_table();
        logic [4:0] vd;
        logic [4:0] vs1;
        vd = 5'd8;
        load_vector(5'd1, $urandom);
        load_vector(5'd2, $urandom);
        // All four lanes active again after the loads
        for (int o = 0; o < 10; o++) begin
            for (int f = 0; f < 3; f++) begin
                vs1 = (f == 2) ? 5'($urandom) : 5'd1;
                add_row(encode(riscv_v_opcode_e'(o), riscv_v_form_e'(f), 1'b1, 5'd2, vs1, vd),
                        $urandom, vd, (o == 0 && f == 0) ? 4 : -1, 0, 0, 0);
                vd = (vd == 5'd23) ? 5'd8 : vd + 5'd1;
            end
        end
        // Equal lanes for vmseq
        add_row(encode(VMSEQ, FORM_VV, 1'b1, 5'd1, 5'd1, 5'd9), 0, 5'd9, -1, 0, 0, 0);
        add_row(encode(VMSEQ, FORM_VX, 1'b1, 5'd1, 5'd0, 5'd10), model_vrf[1][23:16], 5'd10,
                -1, 0, 0, 0);
        // v0 enables lanes 0 and 2, then vl drops to 2
        add_row(encode(VMV_V_X, FORM_VX, 1'b1, 5'd0, 5'd0, 5'd0), 32'h05, 5'd0, -1, 0, 0, 0);
        add_row(encode(VADD, FORM_VV, 1'b0, 5'd2, 5'd1, 5'd11), 0, 5'd11, -1, 0, 0, 0);
        add_row(encode(VXOR, FORM_VX, 1'b1, 5'd2, 5'd0, 5'd12), $urandom, 5'd12, 2, 0, 0, 0);
        add_row(encode(VMSLT, FORM_VV, 1'b0, 5'd2, 5'd1, 5'd13), 0, 5'd13, -1, 0, 0, 0);
        add_row(encode(VMSEQ, FORM_VV, 1'b0, 5'd1, 5'd1, 5'd14), 0, 5'd14, -1, 0, 0, 0);
        // Integer moves, the second from a negative element
        add_row(encode(VMV_X_S, FORM_VV, 1'b1, 5'd1, 5'd0, 5'd1), 0, 5'd1, 4, 0, 0, 0);
        add_row(encode(VMV_V_X, FORM_VX, 1'b1, 5'd0, 5'd0, 5'd24), 32'h9c, 5'd24, -1, 0, 0, 0);
        add_row(encode(VMV_X_S, FORM_VV, 1'b1, 5'd24, 5'd0, 5'd3), 0, 5'd3, -1, 0, 0, 0);
        // Dependent pairs in consecutive cycles
        add_row(encode(VADD, FORM_VX, 1'b1, 5'd1, 5'd0, 5'd25), $urandom, 5'd25, -1, 0, 0, 0);
        add_row(encode(VSUB, FORM_VV, 1'b1, 5'd25, 5'd2, 5'd26), 0, 5'd26, -1, 0, 0, 1);
        add_row(encode(VMV_V_X, FORM_VX, 1'b1, 5'd0, 5'd0, 5'd0), 32'h0a, 5'd0, -1, 0, 0, 0);
        add_row(encode(VOR, FORM_VV, 1'b0, 5'd25, 5'd26, 5'd25), 0, 5'd25, -1, 0, 0, 1);
        // Stalled write, then a stalled write cancelled by clear_pipe
        add_row(encode(VADD, FORM_VV, 1'b1, 5'd2, 5'd1, 5'd27), 0, 5'd27, -1, 2, 0, 0);
        add_row(encode(VSUB, FORM_VV, 1'b1, 5'd2, 5'd1, 5'd8), 0, 5'd8, -1, 2, 1, 0);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic run_group(input int first, input int last);
        int start_errors;
        int exp_pulses;
        start_errors = errors;
        exp_pulses = 0;
        int_pulses = 0;
        if (rows[first].vl_wr) begin
            @(posedge clk);
            ext_wr_vl   <= 1'b1;
            ext_data_in <= rows[first].vl_val;
        end
        for (int k = first; k < last; k++) begin
            @(posedge clk);
            ext_wr_vl            <= 1'b0;
            instruction_id       <= rows[k].instr;
            instruction_valid_id <= 1'b1;
            int_rf_rd_data_id    <= rows[k].scalar;
            syn_addr             <= rows[first].rd;
            exp_pulses += rows[k].exp_int_en;
        end
        @(posedge clk);
        instruction_valid_id <= 1'b0;
        if (rows[first].stall > 0) begin
            riscv_stall <= 1'b1;
            clear_pipe  <= rows[first].clear;
            repeat (rows[first].stall) begin
                @(posedge clk);
                clear_pipe <= 1'b0;
                @(negedge clk);
                check_value("syn_data under stall", rows[first].old_vec, syn_data);
            end
            @(posedge clk);
            riscv_stall <= 1'b0;
        end
        for (int k = first; k < last; k++) begin
            @(posedge clk);
            syn_addr <= rows[k].rd;
            @(negedge clk);
            check_value("syn_data", rows[k].exp_vec, syn_data);
        end
        @(posedge clk);
        @(negedge clk);
        @(posedge clk);
        check_value("int_rf_wr_en_wb cycles", exp_pulses, int_pulses);
        if (rows[first].exp_int_en) begin
            check_value("int_rf_wr_data_wb", rows[first].exp_int, int_seen);
        end
        for (int k = first; k < last; k++) begin
            $display("test %0d instr %h: %s", k, rows[k].instr,
                     (errors == start_errors) ? "ok" : "mismatch");
        end
    endtask

    always @(negedge clk) begin
        if (int_rf_wr_en_wb === 1'b1) begin
            int_pulses++;
            int_seen = int_rf_wr_data_wb;
        end
    end

    initial begin
        int seed;
        int first;
        int last;
        seed = $urandom(32'h313c);
        reset = 1'b1;
        clear_pipe = 1'b0;
        riscv_stall = 1'b0;
        instruction_id = '0;
        instruction_valid_id = 1'b0;
        int_rf_rd_data_id = '0;
        ext_data_in = '0;
        ext_wr_vl = 1'b0;
        syn_addr = '0;
        errors = 0;
        model_vl = 4;
        for (int i = 0; i < 32; i++) begin
            model_vrf[i] = '0;
        end
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        first = 0;
        while (first < rows.size()) begin
            last = first + 1;
            while (last < rows.size() && rows[last].chain) begin
                last++;
            end
            run_group(first, last);
            first = last;
        end
        $display("%0d tests run, %0d checks failed", rows.size(), errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (table_ready);
        repeat (rows.size() * 5 + 100) @(posedge clk);
        $display("Timeout: the test table did not finish within its cycle budget");
        $display("Verification failed");
        $finish;
    end

endmodule: riscv_v_tb
